// ==== flist.f ====
hw/hl_ctrl_pkg.sv
hw/cmd_if.sv
hw/ds_cmd_parser.sv
hw/radio_control.sv
hw/ad9866_spi.sv
hw/hermeslite_ctrl.sv
tb/tb_clock.sv
tb/tb_hermeslite_ctrl.sv

// ==== hw/ad9866_spi.sv ====
//////////////////////////////
// AD9866 3-wire serial writer, 16 bits MSB first
//////////////////////////////

`timescale 1ns/1ps

module ad9866_spi #(
  parameter int SPI_CLK_DIV = 4
) (
  input  logic                  clk_ctrl,
  input  logic                  rst_i,
  input  logic                  spi_rqst_i,
  input  hl_ctrl_pkg::spi_word_t spi_word_i,
  output logic                  spi_busy_o,
  output logic                  sclk_o,
  output logic                  sdio_o,
  output logic                  sen_n_o
);
  import hl_ctrl_pkg::*;

  // Counter spans one full bit of 2*SPI_CLK_DIV cycles
  localparam int DIV_W = $clog2(2 * SPI_CLK_DIV);
  localparam logic [DIV_W-1:0] MID_BIT = DIV_W'(SPI_CLK_DIV - 1);
  localparam logic [DIV_W-1:0] END_BIT = DIV_W'(2 * SPI_CLK_DIV - 1);

  logic             active_q;
  logic             sclk_q;
  logic [DIV_W-1:0] div_cnt_q;
  logic [3:0]       bit_cnt_q;
  spi_word_t        shreg_q;

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      active_q  <= 1'b0;
      sclk_q    <= 1'b0;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
      shreg_q   <= '0;
    end else if (!active_q) begin
      if (spi_rqst_i) begin
        active_q  <= 1'b1;
        div_cnt_q <= '0;
        bit_cnt_q <= '0;
        shreg_q   <= spi_word_i;
      end
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
      if (div_cnt_q == MID_BIT) begin
        sclk_q <= 1'b1;
      end
      if (div_cnt_q == END_BIT) begin
        // Next bit goes out with the falling sclk
        sclk_q    <= 1'b0;
        div_cnt_q <= '0;
        shreg_q   <= {shreg_q[14:0], 1'b0};
        bit_cnt_q <= bit_cnt_q + 4'd1;
        if (bit_cnt_q == 4'd15) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // Register empties after the 16th shift so sdio idles low
  assign sdio_o     = shreg_q[15];
  assign sclk_o     = sclk_q;
  assign sen_n_o    = ~active_q;
  assign spi_busy_o = active_q;

endmodule

// ==== hw/cmd_if.sv ====
//////////////////////////////
// One decoded command, parser to control block
//////////////////////////////

`timescale 1ns/1ps

interface cmd_if;
  import hl_ctrl_pkg::*;

  cmd_addr_t cmd_addr;
  cmd_data_t cmd_data;
  logic      cmd_ptt;
  logic      cmd_resp_rqst;
  // Fields above are valid while this is high
  logic      cmd_strobe;

  modport parser (
    output cmd_addr, cmd_data, cmd_ptt, cmd_resp_rqst, cmd_strobe
  );

  modport ctrl (
    input  cmd_addr, cmd_data, cmd_ptt, cmd_resp_rqst, cmd_strobe
  );

endinterface

// ==== hw/ds_cmd_parser.sv ====
//////////////////////////////
// Protocol-1 downstream parser
// Finds start/stop packets and command frames in the UDP byte stream
//////////////////////////////

`timescale 1ns/1ps

module ds_cmd_parser (
  input  logic                  clk_ctrl,
  input  logic                  rst_i,
  input  logic                  udp_rx_active_i,
  input  hl_ctrl_pkg::eth_byte_t udp_rx_data_i,
  output logic                  run_load_o,
  output logic                  run_value_o,
  cmd_if.parser                 cmd
);
  import hl_ctrl_pkg::*;

  parser_state_e state_q;
  logic [1:0]    sync_cnt_q;
  logic          run_load_q;
  logic          run_value_q;
  logic          strobe_q;

  // Frame fields gathered before C4
  cmd_addr_t     addr_q;
  logic          ptt_q;
  logic          resp_rqst_q;
  logic [23:0]   data_q;

  //////////////////////////////
  // Header and frame FSM
  //////////////////////////////
  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      state_q    <= IDLE;
      sync_cnt_q <= '0;
      run_load_q <= 1'b0;
      strobe_q   <= 1'b0;
    end else begin
      run_load_q <= 1'b0;
      strobe_q   <= 1'b0;
      if (!udp_rx_active_i) begin
        // End of packet
        state_q <= IDLE;
      end else begin
        case (state_q)
          IDLE: begin
            state_q <= (udp_rx_data_i == HDR_SYNC0) ? HDR1 : DRAIN;
          end
          HDR1: begin
            state_q <= (udp_rx_data_i == HDR_SYNC1) ? HDR2 : DRAIN;
          end
          HDR2: begin
            sync_cnt_q <= '0;
            if (udp_rx_data_i == HDR_TYPE_DATA) begin
              state_q <= SYNC;
            end else if (udp_rx_data_i == HDR_TYPE_START) begin
              state_q <= START_ARG;
            end else begin
              state_q <= DRAIN;
            end
          end
          START_ARG: begin
            run_load_q <= 1'b1;
            state_q    <= DRAIN;
          end
          SYNC: begin
            if (udp_rx_data_i != FRAME_SYNC) begin
              state_q <= DRAIN;
            end else if (sync_cnt_q == 2'd2) begin
              state_q <= C0;
            end else begin
              sync_cnt_q <= sync_cnt_q + 2'd1;
            end
          end
          C0: state_q <= C1;
          C1: state_q <= C2;
          C2: state_q <= C3;
          C3: state_q <= C4;
          C4: begin
            strobe_q <= 1'b1;
            state_q  <= DRAIN;
          end
          default: state_q <= DRAIN;
        endcase
      end
    end
  end

  //////////////////////////////
  // Payload capture
  //////////////////////////////
  always_ff @(posedge clk_ctrl) begin
    if (udp_rx_active_i) begin
      case (state_q)
        START_ARG: run_value_q <= udp_rx_data_i[0];
        C0: begin
          ptt_q       <= udp_rx_data_i[0];
          addr_q      <= udp_rx_data_i[6:1];
          resp_rqst_q <= udp_rx_data_i[7];
        end
        // C1 lands in the top byte
        C1, C2, C3: data_q <= {data_q[15:0], udp_rx_data_i};
        C4: begin
          // Publish the whole command together with the strobe
          cmd.cmd_addr      <= addr_q;
          cmd.cmd_ptt       <= ptt_q;
          cmd.cmd_resp_rqst <= resp_rqst_q;
          cmd.cmd_data      <= {data_q, udp_rx_data_i};
        end
        default: ;
      endcase
    end
  end

  assign cmd.cmd_strobe = strobe_q;
  assign run_load_o     = run_load_q;
  assign run_value_o    = run_value_q;

endmodule

// ==== hw/hermeslite_ctrl.sv ====
//////////////////////////////
// Control-clock top: command parser, radio control, AD9866 serial port
//////////////////////////////

`timescale 1ns/1ps

module hermeslite_ctrl #(
  parameter logic [7:0] HERMES_SERIALNO = 8'd62,
  parameter int         SPI_CLK_DIV     = 4
) (
  input  logic                  clk_ctrl,
  input  logic                  rst_i,

  // UDP receive byte stream
  input  logic                  udp_rx_active_i,
  input  hl_ctrl_pkg::eth_byte_t udp_rx_data_i,

  // Receiver status
  input  logic                  rxclip_i,
  input  logic                  rxgoodlvl_i,

  // Radio control
  output logic                  run_o,
  output logic                  pa_tr_o,
  output logic                  rfsw_sel_o,
  output hl_ctrl_pkg::pga_t     rffe_ad9866_pga_o,
  output logic [3:0]            io_led_o,

  // AD9866 serial port
  output logic                  rffe_ad9866_sclk_o,
  output logic                  rffe_ad9866_sdio_o,
  output logic                  rffe_ad9866_sen_n_o,

  // Command response
  output hl_ctrl_pkg::resp_t    resp_o,
  output logic                  resp_valid_o
);
  import hl_ctrl_pkg::*;

  logic      run_load;
  logic      run_value;
  logic      spi_rqst;
  logic      spi_busy;
  spi_word_t spi_word;

  cmd_if cmd_bus ();

  //////////////////////////////
  // Downstream parsing
  //////////////////////////////
  ds_cmd_parser ds_cmd_parser_inst (
    .clk_ctrl        (clk_ctrl),
    .rst_i           (rst_i),
    .udp_rx_active_i (udp_rx_active_i),
    .udp_rx_data_i   (udp_rx_data_i),
    .run_load_o      (run_load),
    .run_value_o     (run_value),
    .cmd             (cmd_bus.parser)
  );

  radio_control #(
    .HERMES_SERIALNO (HERMES_SERIALNO)
  ) radio_control_inst (
    .clk_ctrl     (clk_ctrl),
    .rst_i        (rst_i),
    .cmd          (cmd_bus.ctrl),
    .run_load_i   (run_load),
    .run_value_i  (run_value),
    .rxclip_i     (rxclip_i),
    .rxgoodlvl_i  (rxgoodlvl_i),
    .spi_busy_i   (spi_busy),
    .spi_rqst_o   (spi_rqst),
    .spi_word_o   (spi_word),
    .run_o        (run_o),
    .pa_tr_o      (pa_tr_o),
    .rfsw_sel_o   (rfsw_sel_o),
    .pga_o        (rffe_ad9866_pga_o),
    .led_o        (io_led_o),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o)
  );

  //////////////////////////////
  // AD9866 configuration port
  //////////////////////////////
  ad9866_spi #(
    .SPI_CLK_DIV (SPI_CLK_DIV)
  ) ad9866_spi_inst (
    .clk_ctrl   (clk_ctrl),
    .rst_i      (rst_i),
    .spi_rqst_i (spi_rqst),
    .spi_word_i (spi_word),
    .spi_busy_o (spi_busy),
    .sclk_o     (rffe_ad9866_sclk_o),
    .sdio_o     (rffe_ad9866_sdio_o),
    .sen_n_o    (rffe_ad9866_sen_n_o)
  );

endmodule

// ==== hw/hl_ctrl_pkg.sv ====
//////////////////////////////
// Control-clock shared types, protocol-1 constants and parser states
//////////////////////////////

package hl_ctrl_pkg;

  //////////////////////////////
  // Data widths
  //////////////////////////////
  typedef logic [7:0]  eth_byte_t;
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  typedef logic [39:0] resp_t;
  typedef logic [15:0] spi_word_t;
  typedef logic [5:0]  pga_t;

  //////////////////////////////
  // Protocol-1 framing
  //////////////////////////////
  localparam eth_byte_t HDR_SYNC0      = 8'hEF;
  localparam eth_byte_t HDR_SYNC1      = 8'hFE;
  localparam eth_byte_t HDR_TYPE_DATA  = 8'h01;
  localparam eth_byte_t HDR_TYPE_START = 8'h04;
  // Sent three times ahead of C0
  localparam eth_byte_t FRAME_SYNC     = 8'h7F;

  // Command register addresses
  localparam cmd_addr_t ADDR_PGA        = 6'h0A;
  localparam cmd_addr_t ADDR_AD9866_SPI = 6'h3B;

  // AD9866 power-up default serial word
  localparam spi_word_t AD9866_DEFAULT_WORD = 16'h0400;

  // Parser states, each named after the byte it expects next
  typedef enum logic [3:0] {
    IDLE,
    HDR1,
    HDR2,
    START_ARG,
    SYNC,
    C0,
    C1,
    C2,
    C3,
    C4,
    DRAIN
  } parser_state_e;

endpackage

// ==== hw/radio_control.sv ====
//////////////////////////////
// Radio control state, sticky status, AD9866 writes and responses
//////////////////////////////

`timescale 1ns/1ps

module radio_control #(
  parameter logic [7:0] HERMES_SERIALNO = 8'd62
) (
  input  logic                  clk_ctrl,
  input  logic                  rst_i,
  cmd_if.ctrl                   cmd,
  input  logic                  run_load_i,
  input  logic                  run_value_i,
  input  logic                  rxclip_i,
  input  logic                  rxgoodlvl_i,
  input  logic                  spi_busy_i,
  output logic                  spi_rqst_o,
  output hl_ctrl_pkg::spi_word_t spi_word_o,
  output logic                  run_o,
  output logic                  pa_tr_o,
  output logic                  rfsw_sel_o,
  output hl_ctrl_pkg::pga_t     pga_o,
  output logic [3:0]            led_o,
  output hl_ctrl_pkg::resp_t    resp_o,
  output logic                  resp_valid_o
);
  import hl_ctrl_pkg::*;

  logic      run_q;
  logic      ptt_q;
  pga_t      pga_q;
  logic      clip_q;
  logic      goodlvl_q;
  logic      overrun_q;
  logic      spi_rqst_q;
  spi_word_t spi_word_q;
  resp_t     resp_q;
  logic      resp_valid_q;

  logic      is_pga;
  logic      is_spi;
  logic      spi_accept;
  logic      spi_drop;
  logic      sticky_clr;
  pga_t      pga_nxt;
  spi_word_t spi_word_nxt;

  //////////////////////////////
  // Command decode
  //////////////////////////////
  assign is_pga     = cmd.cmd_strobe && (cmd.cmd_addr == ADDR_PGA);
  assign is_spi     = cmd.cmd_strobe && (cmd.cmd_addr == ADDR_AD9866_SPI);
  // Writer counts as busy from the request pulse on
  assign spi_accept = is_spi && !(spi_busy_i || spi_rqst_q);
  assign spi_drop   = is_spi && (spi_busy_i || spi_rqst_q);
  assign sticky_clr = cmd.cmd_strobe && cmd.cmd_resp_rqst;

  assign pga_nxt      = is_pga ? cmd.cmd_data[5:0] : pga_q;
  assign spi_word_nxt = spi_accept ? cmd.cmd_data[15:0] : spi_word_q;

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      run_q        <= 1'b0;
      ptt_q        <= 1'b0;
      pga_q        <= '0;
      clip_q       <= 1'b0;
      goodlvl_q    <= 1'b0;
      overrun_q    <= 1'b0;
      spi_rqst_q   <= 1'b0;
      spi_word_q   <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      if (run_load_i) begin
        run_q <= run_value_i;
      end
      if (cmd.cmd_strobe) begin
        ptt_q <= cmd.cmd_ptt;
      end
      pga_q      <= pga_nxt;
      spi_word_q <= spi_word_nxt;
      spi_rqst_q <= spi_accept;

      // A new event in the clearing cycle still sets the bit
      clip_q    <= (clip_q & ~sticky_clr) | rxclip_i;
      goodlvl_q <= (goodlvl_q & ~sticky_clr) | rxgoodlvl_i;
      overrun_q <= (overrun_q & ~sticky_clr) | spi_drop;

      resp_valid_q <= sticky_clr;
    end
  end

  //////////////////////////////
  // Response word
  //////////////////////////////
  always_ff @(posedge clk_ctrl) begin
    if (sticky_clr) begin
      // Sticky fields as seen before this command
      resp_q <= {cmd.cmd_addr, clip_q, goodlvl_q, HERMES_SERIALNO,
                 pga_nxt, run_q, overrun_q, spi_word_nxt};
    end
  end

  assign spi_rqst_o   = spi_rqst_q;
  assign spi_word_o   = spi_word_q;
  assign run_o        = run_q;
  assign pa_tr_o      = ptt_q & run_q;
  assign rfsw_sel_o   = ptt_q & run_q;
  assign pga_o        = pga_q;
  assign led_o        = {goodlvl_q, clip_q, ptt_q & run_q, run_q};
  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the control-clock testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module tb_hermeslite_ctrl --Mdir obj_dir &&
  ./obj_dir/Vtb_hermeslite_ctrl | tee /dev/stderr | grep -q "Simulation passed" &&
  echo "run_sim: PASS" ||
  { echo "run_sim: FAIL"; exit 1; }

// ==== tb/tb_clock.sv ====
//////////////////////////////
// Testbench clock source
//////////////////////////////

`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  logic clk_q = 1'b0;

  always #(PERIOD_NS / 2) clk_q = ~clk_q;

  assign clk_o = clk_q;

endmodule

// ==== tb/tb_hermeslite_ctrl.sv ====
//////////////////////////////
// Testbench for the control-clock top
// Sends protocol-1 packets and checks control, response and serial port
//////////////////////////////

`timescale 1ns/1ps

module tb_hermeslite_ctrl;
  import hl_ctrl_pkg::*;

  localparam logic [7:0] SERIALNO = 8'd62;
  localparam int SPI_CLK_DIV = 4;
  localparam int SPI_CYCLES = 32 * SPI_CLK_DIV + 1;
  // 16 packets of at most 14 cycles, three serial windows, then reset and slack
  localparam int WATCHDOG_CYCLES = 16 * 14 + 3 * SPI_CYCLES + 200;

  logic clk_ctrl;
  logic rst_i = 1'b1;
  logic udp_rx_active_i = 1'b0;
  eth_byte_t udp_rx_data_i = '0;
  logic rxclip_i = 1'b0;
  logic rxgoodlvl_i = 1'b0;
  logic run_o, pa_tr_o, rfsw_sel_o, resp_valid_o;
  logic rffe_ad9866_sclk_o, rffe_ad9866_sdio_o, rffe_ad9866_sen_n_o;
  pga_t rffe_ad9866_pga_o;
  logic [3:0] io_led_o;
  resp_t resp_o;

  // Scoreboard
  logic exp_run, exp_ptt, exp_clip, exp_good, exp_overrun;
  pga_t exp_pga;
  spi_word_t exp_word;
  int spi_busy_until = -1;

  int seed = 60706;
  int cycle = 0;
  int errors = 0;
  int sen_errors = 0;
  int switch_errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int mark = 0;
  eth_byte_t pkt[$];

  // Serial port monitor state
  logic sclk_prev = 1'b0;
  logic sen_prev = 1'b1;
  int sclk_rises = 0;
  int done_rises = 0;
  int spi_done_count = 0;
  spi_word_t shift_word = '0;
  spi_word_t done_word = '0;

  tb_clock clock_gen (.clk_o(clk_ctrl));

  hermeslite_ctrl #(
    .HERMES_SERIALNO (SERIALNO),
    .SPI_CLK_DIV     (SPI_CLK_DIV)
  ) hermeslite_ctrl_inst (.*);

  always @(posedge clk_ctrl) cycle <= cycle + 1;

  //////////////////////////////
  // Concurrent checks
  //////////////////////////////
  sclk_idle_when_deselected: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    rffe_ad9866_sen_n_o |-> !rffe_ad9866_sclk_o)
    else begin
      sen_errors++;
      $display("sclk was high while sen_n was high at %0t", $time);
    end

  switch_follows_pa: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    rfsw_sel_o == pa_tr_o)
    else begin
      switch_errors++;
      $display("rfsw_sel_o and pa_tr_o disagree at %0t", $time);
    end

  // Collects sdio at every sclk rise while a word is framed by sen_n
  always @(negedge clk_ctrl) begin
    if (sen_prev && !rffe_ad9866_sen_n_o) begin
      sclk_rises = 0;
      shift_word = '0;
    end
    if (!sclk_prev && rffe_ad9866_sclk_o) begin
      sclk_rises++;
      shift_word = {shift_word[14:0], rffe_ad9866_sdio_o};
    end
    if (!sen_prev && rffe_ad9866_sen_n_o) begin
      done_rises = sclk_rises;
      done_word = shift_word;
      spi_done_count++;
    end
    sclk_prev = rffe_ad9866_sclk_o;
    sen_prev = rffe_ad9866_sen_n_o;
  end

  function automatic int total_errors();
    return errors + sen_errors + switch_errors;
  endfunction

  task automatic check_value(input string name, input logic [39:0] got,
                             input logic [39:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  task automatic check_outputs();
    logic pa;
    pa = exp_run & exp_ptt;
    check_value("run_o", 40'(run_o), 40'(exp_run));
    check_value("pa_tr_o", 40'(pa_tr_o), 40'(pa));
    check_value("rfsw_sel_o", 40'(rfsw_sel_o), 40'(pa));
    check_value("rffe_ad9866_pga_o", 40'(rffe_ad9866_pga_o), 40'(exp_pga));
    check_value("io_led_o", 40'(io_led_o), 40'({exp_good, exp_clip, pa, exp_run}));
  endtask

  // Ends one cycle after the last byte is sampled
  task automatic send_packet();
    foreach (pkt[i]) begin
      @(negedge clk_ctrl);
      udp_rx_active_i = 1'b1;
      udp_rx_data_i = pkt[i];
    end
    @(negedge clk_ctrl);
    udp_rx_active_i = 1'b0;
    udp_rx_data_i = '0;
  endtask

  task automatic build_frame(input eth_byte_t c0, input cmd_data_t data);
    pkt.delete();
    pkt.push_back(HDR_SYNC0);
    pkt.push_back(HDR_SYNC1);
    pkt.push_back(HDR_TYPE_DATA);
    repeat (3) pkt.push_back(FRAME_SYNC);
    pkt.push_back(c0);
    for (int i = 3; i >= 0; i--) pkt.push_back(data[8*i +: 8]);
  endtask

  task automatic send_start(input logic run);
    pkt.delete();
    pkt.push_back(HDR_SYNC0);
    pkt.push_back(HDR_SYNC1);
    pkt.push_back(HDR_TYPE_START);
    pkt.push_back({7'h00, run});
    send_packet();
    check_outputs();
    exp_run = run;
    @(negedge clk_ctrl);
    check_outputs();
  endtask

  task automatic send_ignored();
    send_packet();
    @(negedge clk_ctrl);
    check_outputs();
    check_value("resp_valid_o", 40'(resp_valid_o), 40'(0));
  endtask

  task automatic send_command(input cmd_addr_t addr, input logic ptt, input logic rqst,
                              input cmd_data_t data);
    resp_t exp_resp;
    logic drop;
    int strobe_edge;
    build_frame({rqst, addr, ptt}, data);
    send_packet();
    // Nothing may move one cycle after C4
    check_outputs();
    check_value("resp_valid_o", 40'(resp_valid_o), 40'(0));
    strobe_edge = cycle + 1;
    drop = (addr == ADDR_AD9866_SPI) && (strobe_edge <= spi_busy_until);
    if (addr == ADDR_PGA) exp_pga = data[5:0];
    if (addr == ADDR_AD9866_SPI && !drop) begin
      exp_word = data[15:0];
      spi_busy_until = strobe_edge + 1 + 32 * SPI_CLK_DIV;
    end
    exp_resp = {addr, exp_clip, exp_good, SERIALNO, exp_pga, exp_run, exp_overrun, exp_word};
    exp_ptt = ptt;
    if (rqst) begin
      exp_clip = 1'b0;
      exp_good = 1'b0;
      exp_overrun = 1'b0;
    end
    exp_overrun = exp_overrun | drop;
    @(negedge clk_ctrl);
    check_outputs();
    check_value("resp_valid_o", 40'(resp_valid_o), 40'(rqst));
    if (rqst) check_value("resp_o", resp_o, exp_resp);
    @(negedge clk_ctrl);
    check_value("resp_valid_o", 40'(resp_valid_o), 40'(0));
  endtask

  task automatic pulse_status(input logic clip, input logic good);
    @(negedge clk_ctrl);
    rxclip_i = clip;
    rxgoodlvl_i = good;
    @(negedge clk_ctrl);
    rxclip_i = 1'b0;
    rxgoodlvl_i = 1'b0;
    exp_clip = exp_clip | clip;
    exp_good = exp_good | good;
    check_outputs();
  endtask

  task automatic await_serial_word(input int start, input spi_word_t want);
    int waited;
    waited = 0;
    while (spi_done_count == start && waited < SPI_CYCLES + 16) begin
      @(negedge clk_ctrl);
      waited++;
    end
    checks++;
    assert (spi_done_count != start) else begin
      errors++;
      $display("Serial write did not finish within %0d cycles", waited);
    end
    check_value("rffe_ad9866_sclk_o rises", 40'(done_rises), 40'(16));
    check_value("rffe_ad9866_sdio_o word", 40'(done_word), 40'(want));
  endtask

  task automatic finish_test(input string name);
    int now;
    now = total_errors();
    tests_run++;
    if (now == mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, now - mark);
    end
    mark = now;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin : stimulus
    cmd_data_t data;
    cmd_data_t first;
    int start;
    {exp_run, exp_ptt, exp_clip, exp_good, exp_overrun} = '0;
    exp_pga = '0;
    exp_word = '0;
    repeat (2) @(negedge clk_ctrl);
    rst_i = 1'b0;

    check_outputs();
    check_value("resp_valid_o", 40'(resp_valid_o), 40'(0));
    check_value("rffe_ad9866_sclk_o", 40'(rffe_ad9866_sclk_o), 40'(0));
    check_value("rffe_ad9866_sdio_o", 40'(rffe_ad9866_sdio_o), 40'(0));
    check_value("rffe_ad9866_sen_n_o", 40'(rffe_ad9866_sen_n_o), 40'(1));
    finish_test("reset state");

    send_start(1'b1);
    send_start(1'b0);
    send_start(1'b1);
    // Third sync byte wrong, then header byte wrong
    build_frame({1'b1, ADDR_PGA, 1'b1}, 32'hFFFF_FFFF);
    pkt[5] = 8'h00;
    send_ignored();
    build_frame({1'b1, ADDR_PGA, 1'b1}, 32'hFFFF_FFFF);
    pkt[1] = 8'hFD;
    send_ignored();
    finish_test("start, stop and bad framing");

    send_start(1'b0);
    send_command(6'h00, 1'b1, 1'b0, $random(seed));
    send_start(1'b1);
    send_command(ADDR_PGA, 1'b1, 1'b0, $random(seed));
    send_command(6'h00, 1'b0, 1'b0, $random(seed));
    finish_test("ptt gating and pga write");

    pulse_status(1'b1, 1'b0);
    send_command(ADDR_PGA, 1'b0, 1'b1, $random(seed));
    pulse_status(1'b0, 1'b1);
    send_command(6'h05, 1'b0, 1'b1, $random(seed));
    finish_test("response and sticky status");

    start = spi_done_count;
    data = $random(seed);
    send_command(ADDR_AD9866_SPI, 1'b0, 1'b0, data);
    await_serial_word(start, data[15:0]);
    finish_test("serial write");

    // Second write lands while the first is still shifting
    start = spi_done_count;
    first = {16'h0000, AD9866_DEFAULT_WORD};
    data = $random(seed);
    data[15:0] = ~first[15:0];
    send_command(ADDR_AD9866_SPI, 1'b0, 1'b0, first);
    send_command(ADDR_AD9866_SPI, 1'b0, 1'b0, data);
    await_serial_word(start, first[15:0]);
    send_command(6'h00, 1'b0, 1'b1, $random(seed));
    // A dropped word must never get a frame of its own
    repeat (SPI_CYCLES) @(negedge clk_ctrl);
    check_value("serial word count", 40'(spi_done_count - start), 40'(1));
    check_value("rffe_ad9866_sen_n_o", 40'(rffe_ad9866_sen_n_o), 40'(1));
    finish_test("serial overrun");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_ctrl);
    $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule
